/* source/cms_config.svh */
/* widths and constants of the trace monitor
   the FIFO depth need not be a power of two, but must be at least 2 */
`ifndef CMS_CONFIG_SVH
`define CMS_CONFIG_SVH

// width of the program counter and of every address setting
`define CMS_XLEN 32

// RV32 instructions are always 32 bits wide in this monitor
`define CMS_INSTR_WIDTH 32

// cycle delta between two records; it wraps silently after 2**32 cycles
`define CMS_DELTA_WIDTH 32

// wfi encoding, used to mark the end of a program run with tlast
`define CMS_WFI_INSTR 32'h10500073

// records held while the stream sink applies back-pressure
`define CMS_FIFO_DEPTH 8

`endif

/* source/cms_pkg.sv */
/* types shared by the trace monitor blocks and the testbench
   trace_record_t is also the bit layout of m_axis_tdata */
`include "cms_config.svh"

package cms_pkg;

    // control register map, written through ctrl_addr and ctrl_wdata
    typedef enum logic [3:0] {
        TRACE_START_EN   = 4'd0,
        TRACE_END_EN     = 4'd1,
        TRACE_START_ADDR = 4'd2,
        TRACE_END_ADDR   = 4'd3,
        WINDOW_LO_EN     = 4'd4,
        WINDOW_HI_EN     = 4'd5,
        WINDOW_LO        = 4'd6,
        WINDOW_HI        = 4'd7
    } ctrl_addr_t;

    // settings currently in force, 132 bits
    typedef struct packed {
        logic                 start_en;
        logic                 end_en;
        logic                 win_lo_en;
        logic                 win_hi_en;
        logic [`CMS_XLEN-1:0] start_addr;
        logic [`CMS_XLEN-1:0] end_addr;
        logic [`CMS_XLEN-1:0] win_lo;
        logic [`CMS_XLEN-1:0] win_hi;
    } monitor_cfg_t;

    // one trace beat, instruction in the top word and pc in the bottom word
    typedef struct packed {
        logic [`CMS_INSTR_WIDTH-1:0] instr;
        logic [`CMS_DELTA_WIDTH-1:0] delta;
        logic [`CMS_XLEN-1:0]        pc;
    } trace_record_t;

    // what the FIFO stores per entry
    typedef struct packed {
        logic          last;
        trace_record_t record;
    } stream_entry_t;

endpackage

/* source/cms_ctrl_regs.sv */
/* control registers of the trace monitor
   a write is taken on the rising edge of ctrl_write_enable, so the strobe must
   drop before the next write; address and data must be stable with the strobe
   the new value and cfg_write appear two cycles after the strobe rises */
`include "cms_config.svh"

module cms_ctrl_regs
    import cms_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  ctrl_addr_t           ctrl_addr,
    input  logic [`CMS_XLEN-1:0] ctrl_wdata,
    input  logic                 ctrl_write_enable,
    output monitor_cfg_t         cfg,
    output logic                 cfg_write
);

    logic                 wen_q;
    logic                 wen_qq;
    ctrl_addr_t           addr_q;
    logic [`CMS_XLEN-1:0] wdata_q;
    logic                 wr_edge;

    // two flops on the strobe, the edge shows up one cycle after the rise
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wen_q  <= 1'b0;
            wen_qq <= 1'b0;
        end else begin
            wen_q  <= ctrl_write_enable;
            wen_qq <= wen_q;
        end
    end

    // address and data are captured alongside the first strobe flop
    always_ff @(posedge clk) begin
        addr_q  <= ctrl_addr;
        wdata_q <= ctrl_wdata;
    end

    assign wr_edge = wen_q & ~wen_qq;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.start_en   <= 1'b0;
            cfg.end_en     <= 1'b0;
            cfg.win_lo_en  <= 1'b0;
            cfg.win_hi_en  <= 1'b0;
            cfg.start_addr <= '0;
            cfg.end_addr   <= '1;
            cfg.win_lo     <= '0;
            cfg.win_hi     <= '1;
            cfg_write      <= 1'b0;
        end else begin
            cfg_write <= 1'b0;
            if (wr_edge) begin
                cfg_write <= 1'b1;
                case (addr_q)
                    TRACE_START_EN:   cfg.start_en   <= wdata_q[0];
                    TRACE_END_EN:     cfg.end_en     <= wdata_q[0];
                    TRACE_START_ADDR: cfg.start_addr <= wdata_q;
                    TRACE_END_ADDR:   cfg.end_addr   <= wdata_q;
                    WINDOW_LO_EN:     cfg.win_lo_en  <= wdata_q[0];
                    WINDOW_HI_EN:     cfg.win_hi_en  <= wdata_q[0];
                    WINDOW_LO:        cfg.win_lo     <= wdata_q;
                    WINDOW_HI:        cfg.win_hi     <= wdata_q;
                    // unmapped addresses change nothing and raise no pulse
                    default:          cfg_write      <= 1'b0;
                endcase
            end
        end
    end

endmodule

/* source/cms_trace_gate.sv */
/* decides which instructions become trace records
   an instruction is decided on two cycles after its pc first appears, so a pc
   held for several cycles gives one record and a stalled core's last one counts
   pc 0 is treated as "core not running" and is never recorded */
`include "cms_config.svh"

module cms_trace_gate
    import cms_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`CMS_XLEN-1:0]        pc,
    input  logic [`CMS_INSTR_WIDTH-1:0] instr,
    input  logic                        en,
    input  monitor_cfg_t                cfg,
    input  logic                        cfg_write,
    output logic                        push,
    output stream_entry_t               entry
);

    // pc and instruction delayed by one and by two cycles
    logic [`CMS_XLEN-1:0]        pc_d1;
    logic [`CMS_XLEN-1:0]        pc_d2;
    logic [`CMS_INSTR_WIDTH-1:0] instr_d1;
    logic [`CMS_INSTR_WIDTH-1:0] instr_d2;

    logic                        start_reached;
    logic                        end_reached;
    logic [`CMS_DELTA_WIDTH-1:0] cycle_cnt;
    logic [`CMS_DELTA_WIDTH-1:0] last_push_ts;

    logic new_instr;
    logic trigger_ok;
    logic in_window;
    logic push_now;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_d1     <= '0;
            pc_d2     <= '0;
            new_instr <= 1'b0;
        end else begin
            pc_d1 <= pc;
            pc_d2 <= pc_d1;
            // travels with pc_d2 and is set when that pc differed from the one before it
            new_instr <= (pc_d1 != pc_d2) && (pc_d1 != '0);
        end
    end

    always_ff @(posedge clk) begin
        instr_d1 <= instr;
        instr_d2 <= instr_d1;
    end

    // start/end triggers look at the live pc, one cycle ahead of pc_d1,
    // so the flags are already settled when pc_d2 reaches the gate
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_reached <= 1'b0;
            end_reached   <= 1'b0;
        end else if (!cfg_write) begin
            if (cfg.start_en && (pc == cfg.start_addr)) begin
                start_reached <= 1'b1;
                end_reached   <= 1'b0;
            end
            // an end match wins when both addresses are the same
            if (cfg.end_en && (pc == cfg.end_addr)) begin
                end_reached   <= 1'b1;
                start_reached <= 1'b0;
            end
        end
    end

    assign trigger_ok = (start_reached || !cfg.start_en) && (!end_reached || !cfg.end_en);

    assign in_window = (!cfg.win_lo_en || (pc_d2 >= cfg.win_lo)) &&
                       (!cfg.win_hi_en || (pc_d2 <= cfg.win_hi));

    assign push_now = en && new_instr && trigger_ok && in_window;

    // the delta is the free-running cycle count minus its value at the last push
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt    <= '0;
            last_push_ts <= '0;
            push         <= 1'b0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
            push      <= push_now;
            if (push_now) begin
                last_push_ts <= cycle_cnt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_now) begin
            entry.last         <= (instr_d2 == `CMS_WFI_INSTR);
            entry.record.instr <= instr_d2;
            entry.record.delta <= cycle_cnt - last_push_ts;
            entry.record.pc    <= pc_d2;
        end
    end

endmodule

/* source/cms_stream_fifo.sv */
/* record FIFO with an AXI-stream master output
   there is no ready towards the writer, a push into a full FIFO is lost
   tdata and tlast hold while tvalid is high and tready is low */
`include "cms_config.svh"

module cms_stream_fifo
    import cms_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          push,
    input  stream_entry_t entry,
    output logic          m_axis_tvalid,
    input  logic          m_axis_tready,
    output trace_record_t m_axis_tdata,
    output logic          m_axis_tlast
);

    localparam int DEPTH = `CMS_FIFO_DEPTH;
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

    stream_entry_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          pop;
    logic          wr;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign m_axis_tvalid = (count != '0);
    assign pop = m_axis_tvalid && m_axis_tready;
    // when full, a pop in the same cycle frees the slot being written
    assign wr = push && ((count != FULL_COUNT) || pop);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= entry;
        end
    end

    assign m_axis_tdata = mem[rd_ptr].record;
    assign m_axis_tlast = mem[rd_ptr].last;

endmodule

/* source/cms_top.sv */
/* continuous trace monitor for a RISC-V core
   pc and instr are sampled every clock, records leave on m_axis
   a record's first beat comes at least three cycles after its pc appears
   records beyond the FIFO depth are dropped under back-pressure */
`include "cms_config.svh"

module cms_top
    import cms_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`CMS_XLEN-1:0]        pc,
    input  logic [`CMS_INSTR_WIDTH-1:0] instr,
    input  logic                        en,
    input  ctrl_addr_t                  ctrl_addr,
    input  logic [`CMS_XLEN-1:0]        ctrl_wdata,
    input  logic                        ctrl_write_enable,
    output logic                        m_axis_tvalid,
    input  logic                        m_axis_tready,
    output trace_record_t               m_axis_tdata,
    output logic                        m_axis_tlast
);

    monitor_cfg_t  cfg;
    logic          cfg_write;
    logic          push;
    stream_entry_t entry;

    cms_ctrl_regs ctrl_regs_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .ctrl_addr         (ctrl_addr),
        .ctrl_wdata        (ctrl_wdata),
        .ctrl_write_enable (ctrl_write_enable),
        .cfg               (cfg),
        .cfg_write         (cfg_write)
    );

    cms_trace_gate trace_gate_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc        (pc),
        .instr     (instr),
        .en        (en),
        .cfg       (cfg),
        .cfg_write (cfg_write),
        .push      (push),
        .entry     (entry)
    );

    cms_stream_fifo stream_fifo_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (push),
        .entry         (entry),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast)
    );

endmodule

/* bench/cms_tb_asserts.sv */
/* handshake checks on the trace stream output of the record FIFO
   all properties are disabled while rst_n is low, except the reset check */
module cms_tb_asserts
    import cms_pkg::*;
(
    input logic          clk,
    input logic          rst_n,
    input logic          m_axis_tvalid,
    input logic          m_axis_tready,
    input trace_record_t m_axis_tdata,
    input logic          m_axis_tlast
);

    timeunit 1ns;
    timeprecision 1ps;

    // a stalled beat stays offered until the sink takes it
    valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        (m_axis_tvalid && !m_axis_tready) |=> m_axis_tvalid)
        else $error("tvalid dropped while a beat was stalled");

    data_held: assert property (@(posedge clk) disable iff (!rst_n)
        (m_axis_tvalid && !m_axis_tready) |=> ($stable(m_axis_tdata) && $stable(m_axis_tlast)))
        else $error("tdata or tlast changed while a beat was stalled");

    // the FIFO comes out of reset empty
    reset_idle: assert property (@(posedge clk) !rst_n |=> !m_axis_tvalid)
        else $error("tvalid high right after reset");

endmodule

bind cms_stream_fifo cms_tb_asserts stream_asserts_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast)
);

/* bench/cms_tb.sv */
/* testbench for the trace monitor top level
   a cycle model built from the pipeline timing predicts every record
   the first record's delta depends on when reset ends and is not checked */
`include "cms_config.svh"

module cms_tb
    import cms_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BEAT_TIMEOUT = 64;
    localparam int DRAIN_LIMIT = 200;

    typedef enum logic {STEP_WRITE, STEP_PC} step_kind_t;

    // a write step uses value as write data, a pc step uses it as the pc
    typedef struct packed {
        step_kind_t           kind;
        ctrl_addr_t           addr;
        logic [`CMS_XLEN-1:0] value;
        logic [31:0]          instr;
        logic [7:0]           cycles;
        logic                 en;
        logic                 random_ready;
    } step_t;

    typedef struct packed {
        logic          delta_known;
        stream_entry_t entry;
    } expect_t;

    logic                        clk;
    logic                        rst_n;
    logic [`CMS_XLEN-1:0]        pc;
    logic [`CMS_INSTR_WIDTH-1:0] instr;
    logic                        en;
    ctrl_addr_t                  ctrl_addr;
    logic [`CMS_XLEN-1:0]        ctrl_wdata;
    logic                        ctrl_write_enable;
    logic                        m_axis_tvalid;
    logic                        m_axis_tready;
    trace_record_t               m_axis_tdata;
    logic                        m_axis_tlast;

    // values applied on the next cycle
    logic [`CMS_XLEN-1:0]        drv_pc;
    logic [`CMS_INSTR_WIDTH-1:0] drv_instr;
    logic                        drv_en;
    logic                        drv_wen;
    ctrl_addr_t                  drv_addr;
    logic [`CMS_XLEN-1:0]        drv_wdata;
    logic                        drv_random_ready;

    // the reference model state moves on once per clock cycle
    logic                        seen_new1;
    logic                        seen_new2;
    logic [`CMS_XLEN-1:0]        seen_pc1;
    logic [`CMS_XLEN-1:0]        seen_pc2;
    logic [`CMS_INSTR_WIDTH-1:0] seen_instr1;
    logic [`CMS_INSTR_WIDTH-1:0] seen_instr2;
    monitor_cfg_t                mdl_cfg;
    logic                        mdl_cfg_write;
    logic                        mdl_edge;
    logic                        mdl_wen_prev;
    ctrl_addr_t                  mdl_addr;
    logic [`CMS_XLEN-1:0]        mdl_wdata;
    logic                        mdl_start;
    logic                        mdl_end;
    logic                        mdl_pushed;
    int                          mdl_cycle;
    int                          mdl_last_push;

    step_t   steps[$];
    expect_t exp_q[$];
    expect_t head;

    logic          prev_stall = 1'b0;
    trace_record_t prev_data;
    logic          prev_last;
    int            idle_cycles = 0;

    cms_top cms_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("FAIL %s: got 0x%h, expected 0x%h",
                                        name, got, expected));
        end
    endtask

    task automatic pc_step(input logic [`CMS_XLEN-1:0] p, input logic [31:0] i,
                           input int hold, input logic e, input logic rr);
        step_t s;
        s = '0;
        s.kind = STEP_PC;
        s.value = p;
        s.instr = i;
        s.cycles = 8'(hold);
        s.en = e;
        s.random_ready = rr;
        steps.push_back(s);
    endtask

    // strobe high for one cycle, then low for three
    task automatic write_step(input ctrl_addr_t a, input logic [`CMS_XLEN-1:0] d);
        step_t s;
        s = '0;
        s.kind = STEP_WRITE;
        s.addr = a;
        s.value = d;
        s.cycles = 8'd4;
        s.en = 1'b1;
        steps.push_back(s);
    endtask

    task automatic build_table();
        // plain records with different hold times
        pc_step(32'h100, 32'h00000093, 1, 1'b1, 1'b0);
        pc_step(32'h104, 32'h00100113, 2, 1'b1, 1'b0);
        pc_step(32'h108, 32'h00208193, 3, 1'b1, 1'b0);
        pc_step(32'h10c, 32'h40310233, 5, 1'b1, 1'b0);
        pc_step(32'h110, 32'h00000013, 6, 1'b1, 1'b0);
        pc_step(32'h000, 32'h00000000, 3, 1'b1, 1'b0);
        pc_step(32'h114, 32'h00400293, 2, 1'b1, 1'b0);
        // recording switched off for a while
        pc_step(32'h200, 32'h00500313, 3, 1'b0, 1'b0);
        pc_step(32'h204, 32'h00600393, 3, 1'b0, 1'b0);
        pc_step(32'h208, 32'h00700413, 3, 1'b1, 1'b0);
        pc_step(32'h20c, 32'h00800493, 3, 1'b1, 1'b0);
        // inclusive address window 0x300..0x30c
        write_step(WINDOW_LO, 32'h300);
        write_step(WINDOW_HI, 32'h30c);
        write_step(WINDOW_LO_EN, 32'h1);
        write_step(WINDOW_HI_EN, 32'h1);
        pc_step(32'h2fc, 32'h00900513, 2, 1'b1, 1'b0);
        pc_step(32'h300, 32'h00a00593, 2, 1'b1, 1'b0);
        pc_step(32'h308, 32'h00b00613, 2, 1'b1, 1'b0);
        pc_step(32'h30c, 32'h00c00693, 2, 1'b1, 1'b0);
        pc_step(32'h310, 32'h00d00713, 2, 1'b1, 1'b0);
        pc_step(32'h304, 32'h00e00793, 2, 1'b1, 1'b0);
        pc_step(32'h2f8, 32'h00f00813, 2, 1'b1, 1'b0);
        write_step(WINDOW_LO_EN, 32'h0);
        write_step(WINDOW_HI_EN, 32'h0);
        pc_step(32'h400, 32'h01000893, 2, 1'b1, 1'b0);
        pc_step(32'h2f0, 32'h01100913, 2, 1'b1, 1'b0);
        pc_step(32'h404, 32'h01200993, 2, 1'b1, 1'b0);
        // start and end trigger
        write_step(TRACE_START_ADDR, 32'h500);
        write_step(TRACE_END_ADDR, 32'h510);
        write_step(TRACE_START_EN, 32'h1);
        write_step(TRACE_END_EN, 32'h1);
        for (int n = 0; n < 9; n++) begin
            pc_step(32'h4f8 + 32'(4 * n), 32'h01300a13 + (32'(n) << 20), 2, 1'b1, 1'b0);
        end
        write_step(TRACE_START_EN, 32'h0);
        write_step(TRACE_END_EN, 32'h0);
        pc_step(32'h520, 32'h01400a93, 2, 1'b1, 1'b0);
        pc_step(32'h524, 32'h01500b13, 2, 1'b1, 1'b0);
        // wfi closes a burst with tlast
        pc_step(32'h600, `CMS_WFI_INSTR, 4, 1'b1, 1'b0);
        pc_step(32'h604, 32'h01600b93, 2, 1'b1, 1'b0);
        pc_step(32'h608, 32'h01700c13, 2, 1'b1, 1'b0);
        // sink stalls at random
        for (int n = 0; n < 16; n++) begin
            pc_step(32'h700 + 32'(4 * n), 32'h00000013 + (32'(n) << 20), 2 + (n % 3),
                    1'b1, 1'b1);
        end
        pc_step(32'h000, 32'h00000000, 6, 1'b1, 1'b0);
    endtask

    task automatic reset_model();
        seen_new1 = 1'b0;
        seen_new2 = 1'b0;
        seen_pc1 = '0;
        seen_pc2 = '0;
        seen_instr1 = '0;
        seen_instr2 = '0;
        mdl_cfg = '0;
        mdl_cfg.end_addr = '1;
        mdl_cfg.win_hi = '1;
        mdl_cfg_write = 1'b0;
        mdl_edge = 1'b0;
        mdl_wen_prev = 1'b0;
        mdl_addr = TRACE_START_EN;
        mdl_wdata = '0;
        mdl_start = 1'b0;
        mdl_end = 1'b0;
        mdl_pushed = 1'b0;
        mdl_cycle = 0;
        mdl_last_push = 0;
    endtask

    task automatic apply_write(input ctrl_addr_t a, input logic [`CMS_XLEN-1:0] d);
        case (a)
            TRACE_START_EN:   mdl_cfg.start_en = d[0];
            TRACE_END_EN:     mdl_cfg.end_en = d[0];
            TRACE_START_ADDR: mdl_cfg.start_addr = d;
            TRACE_END_ADDR:   mdl_cfg.end_addr = d;
            WINDOW_LO_EN:     mdl_cfg.win_lo_en = d[0];
            WINDOW_HI_EN:     mdl_cfg.win_hi_en = d[0];
            WINDOW_LO:        mdl_cfg.win_lo = d;
            default:          mdl_cfg.win_hi = d;
        endcase
    endtask

    // decides on the pc presented two cycles ago, then moves the model one cycle on
    task automatic model_cycle();
        logic    trigger_ok;
        logic    in_window;
        expect_t e;
        trigger_ok = (mdl_start || !mdl_cfg.start_en) && (!mdl_end || !mdl_cfg.end_en);
        in_window = (!mdl_cfg.win_lo_en || (seen_pc2 >= mdl_cfg.win_lo)) &&
                    (!mdl_cfg.win_hi_en || (seen_pc2 <= mdl_cfg.win_hi));
        if (drv_en && seen_new2 && trigger_ok && in_window) begin
            e.delta_known = mdl_pushed;
            e.entry.last = (seen_instr2 == `CMS_WFI_INSTR);
            e.entry.record.instr = seen_instr2;
            e.entry.record.delta = mdl_cycle - mdl_last_push;
            e.entry.record.pc = seen_pc2;
            exp_q.push_back(e);
            mdl_pushed = 1'b1;
            mdl_last_push = mdl_cycle;
            if (exp_q.size() > `CMS_FIFO_DEPTH) begin
                stop_with_failure("stimulus left more records outstanding than the FIFO holds");
            end
        end
        if (!mdl_cfg_write) begin
            if (mdl_cfg.start_en && (drv_pc == mdl_cfg.start_addr)) begin
                mdl_start = 1'b1;
                mdl_end = 1'b0;
            end
            if (mdl_cfg.end_en && (drv_pc == mdl_cfg.end_addr)) begin
                mdl_end = 1'b1;
                mdl_start = 1'b0;
            end
        end
        mdl_cfg_write = mdl_edge;
        if (mdl_edge) begin
            apply_write(mdl_addr, mdl_wdata);
        end
        mdl_edge = drv_wen && !mdl_wen_prev;
        mdl_addr = drv_addr;
        mdl_wdata = drv_wdata;
        mdl_wen_prev = drv_wen;
        // a pc is new when it differs from the previous cycle's pc and is nonzero
        seen_new2 = seen_new1;
        seen_new1 = (drv_pc != seen_pc1) && (drv_pc != '0);
        seen_pc2 = seen_pc1;
        seen_pc1 = drv_pc;
        seen_instr2 = seen_instr1;
        seen_instr1 = drv_instr;
        mdl_cycle++;
    endtask

    task automatic run_cycle();
        @(posedge clk);
        #10;
        pc = drv_pc;
        instr = drv_instr;
        en = drv_en;
        ctrl_addr = drv_addr;
        ctrl_wdata = drv_wdata;
        ctrl_write_enable = drv_wen;
        m_axis_tready = drv_random_ready ? (($urandom % 4) != 0) : 1'b1;
        model_cycle();
    endtask

    task automatic apply_table();
        int n;
        for (n = 0; n < steps.size(); n++) begin
            drv_en = steps[n].en;
            drv_random_ready = steps[n].random_ready;
            if (steps[n].kind == STEP_WRITE) begin
                drv_addr = steps[n].addr;
                drv_wdata = steps[n].value;
                drv_wen = 1'b1;
                run_cycle();
                drv_wen = 1'b0;
                repeat (int'(steps[n].cycles) - 1) run_cycle();
            end else begin
                drv_pc = steps[n].value;
                drv_instr = steps[n].instr;
                repeat (int'(steps[n].cycles)) run_cycle();
            end
        end
    endtask

    task automatic drain_records();
        int n;
        drv_random_ready = 1'b0;
        n = 0;
        while ((exp_q.size() != 0) && (n < DRAIN_LIMIT)) begin
            run_cycle();
            n++;
        end
        if (exp_q.size() != 0) begin
            stop_with_failure("timeout while waiting for the last records to leave the stream");
        end
    endtask

    // outputs are sampled at the falling edge, half a cycle away from any input change
    always @(negedge clk) begin
        if (rst_n) begin
            if (prev_stall) begin
                check_value("m_axis_tdata.instr (stalled)", m_axis_tdata.instr, prev_data.instr);
                check_value("m_axis_tdata.delta (stalled)", m_axis_tdata.delta, prev_data.delta);
                check_value("m_axis_tdata.pc (stalled)", m_axis_tdata.pc, prev_data.pc);
                check_value("m_axis_tlast (stalled)", 32'(m_axis_tlast), 32'(prev_last));
            end
            if (m_axis_tvalid && m_axis_tready) begin
                if (exp_q.size() == 0) begin
                    stop_with_failure("a beat arrived while no record was expected");
                end
                head = exp_q.pop_front();
                check_value("m_axis_tdata.pc", m_axis_tdata.pc, head.entry.record.pc);
                check_value("m_axis_tdata.instr", m_axis_tdata.instr, head.entry.record.instr);
                if (head.delta_known) begin
                    check_value("m_axis_tdata.delta", m_axis_tdata.delta,
                                head.entry.record.delta);
                end
                check_value("m_axis_tlast", 32'(m_axis_tlast), 32'(head.entry.last));
                idle_cycles = 0;
            end else if (exp_q.size() != 0) begin
                idle_cycles++;
                if (idle_cycles > BEAT_TIMEOUT) begin
                    stop_with_failure("timeout while waiting for the next beat");
                end
            end
            prev_stall = m_axis_tvalid && !m_axis_tready;
            prev_data = m_axis_tdata;
            prev_last = m_axis_tlast;
        end
    end

    initial begin
        void'($urandom(32'h6f6659df));
        rst_n = 1'b0;
        pc = '0;
        instr = '0;
        en = 1'b0;
        ctrl_addr = TRACE_START_EN;
        ctrl_wdata = '0;
        ctrl_write_enable = 1'b0;
        m_axis_tready = 1'b1;
        drv_pc = '0;
        drv_instr = '0;
        drv_en = 1'b0;
        drv_wen = 1'b0;
        drv_addr = TRACE_START_EN;
        drv_wdata = '0;
        drv_random_ready = 1'b0;
        reset_model();
        build_table();
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;
        model_cycle();
        apply_table();
        drain_records();
        // a few idle cycles so that a stray extra beat is still caught
        repeat (8) run_cycle();
        if (exp_q.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("%0d expected records never appeared on the stream", exp_q.size());
            $display("*** TEST FAILED ***");
            $fatal(1, "records missing at the end of the run");
        end
    end

endmodule

/* build.f */
+incdir+source
source/cms_pkg.sv
source/cms_ctrl_regs.sv
source/cms_trace_gate.sv
source/cms_stream_fifo.sv
source/cms_top.sv
bench/cms_tb_asserts.sv
bench/cms_tb.sv

/* Makefile */
# Verilator flow for the trace monitor testbench
# a failing run ends in $fatal, so make sim returns a non-zero status

TOP = cms_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
